// File: hw/amo_pkg.sv
// Shared types for the atomic memory unit
// Addresses are word indices, so there are no byte sizes and no alignment checks
// Command codes follow the RISC-V funct5 values, and LR/SC are reused as plain load/store
// Codes outside cmd_code_e are legal inputs and decode as illegal commands

package amo_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] addr_t; // Memory keeps only the low index bits
    typedef logic [3:0]  tag_t;

    localparam int DEFAULT_DEPTH = 32;

    typedef enum logic [4:0] {
        CMD_AMOADD  = 5'd0,
        CMD_AMOSWAP = 5'd1,
        CMD_LOAD    = 5'd2, // LR slot
        CMD_STORE   = 5'd3, // SC slot
        CMD_AMOXOR  = 5'd4,
        CMD_AMOOR   = 5'd8,
        CMD_AMOAND  = 5'd12,
        CMD_AMOMIN  = 5'd16,
        CMD_AMOMAX  = 5'd20,
        CMD_AMOMINU = 5'd24,
        CMD_AMOMAXU = 5'd28
    } cmd_code_e;

    typedef enum logic [1:0] {
        MEM_OP_NONE,
        MEM_OP_LOAD,
        MEM_OP_STORE,
        MEM_OP_AMO
    } mem_op_e;

    typedef enum logic [3:0] {
        AMO_OP_SWAP,
        AMO_OP_ADD,
        AMO_OP_AND,
        AMO_OP_OR,
        AMO_OP_XOR,
        AMO_OP_MIN,
        AMO_OP_MAX,
        AMO_OP_MINU,
        AMO_OP_MAXU
    } amo_op_e;

    typedef struct packed {
        cmd_code_e cmd;
        addr_t     addr;
        word_t     wdata;
        tag_t      tag;
    } amo_req_s;

    typedef struct packed {
        mem_op_e mem_op;
        amo_op_e amo_op;
        addr_t   addr;
        word_t   wdata;
        tag_t    tag;
        logic    illegal;
    } dec_to_exe_s;

    typedef struct packed {
        tag_t    tag;
        mem_op_e mem_op;
        logic    illegal;
        word_t   mem_rdata; // Memory word before the write
    } exe_to_res_s;

    typedef struct packed {
        tag_t  tag;
        word_t rdata;
        logic  illegal;
    } amo_rsp_s;

endpackage : amo_pkg

// File: hw/amo_decode.sv
// Decode stage of the atomic memory unit
// Accepts one command per clock as a strobe and never refuses one
// Commands presented while stall is high are dropped, not queued
// Unknown codes are passed on as illegal with no memory access

`timescale 1ns/1ps

module amo_decode
    import amo_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  amo_req_s    req,
    input  logic        stall,
    input  logic        flush,
    output logic        dec_valid,
    output dec_to_exe_s dec,
    output logic        rd_en,
    output addr_t       rd_addr
);

    dec_to_exe_s dec_next;

    always_comb begin
        dec_next         = '0;
        dec_next.addr    = req.addr;
        dec_next.wdata   = req.wdata;
        dec_next.tag     = req.tag;
        dec_next.mem_op  = MEM_OP_AMO; // Overridden below for the non-AMO codes
        dec_next.amo_op  = AMO_OP_SWAP;
        dec_next.illegal = 1'b0;

        case (req.cmd)
            CMD_LOAD:    dec_next.mem_op = MEM_OP_LOAD;
            CMD_STORE:   dec_next.mem_op = MEM_OP_STORE;
            CMD_AMOSWAP: dec_next.amo_op = AMO_OP_SWAP;
            CMD_AMOADD:  dec_next.amo_op = AMO_OP_ADD;
            CMD_AMOAND:  dec_next.amo_op = AMO_OP_AND;
            CMD_AMOOR:   dec_next.amo_op = AMO_OP_OR;
            CMD_AMOXOR:  dec_next.amo_op = AMO_OP_XOR;
            CMD_AMOMIN:  dec_next.amo_op = AMO_OP_MIN;
            CMD_AMOMAX:  dec_next.amo_op = AMO_OP_MAX;
            CMD_AMOMINU: dec_next.amo_op = AMO_OP_MINU;
            CMD_AMOMAXU: dec_next.amo_op = AMO_OP_MAXU;
            default: begin
                dec_next.mem_op  = MEM_OP_NONE;
                dec_next.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0; // The command held here is dropped
        end else if (!stall) begin
            dec_valid <= req_valid;
        end
    end

    // Payload needs no reset, dec_valid qualifies it
    always_ff @(posedge clk) begin
        if (!stall) begin
            dec <= dec_next;
        end
    end

    // The read lands in the memory register at the same edge execute takes the command
    assign rd_en   = dec_valid && !dec.illegal;
    assign rd_addr = dec.addr;

endmodule : amo_decode

// File: hw/amo_execute.sv
// Execute stage of the atomic memory unit
// rd_data must be the word read at the edge that loaded the input register
// Memory forwarding makes back-to-back commands to one address safe
// DEPTH must be a power of two of at least 2, as the write index wraps on it

`timescale 1ns/1ps

module amo_execute
    import amo_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic        dec_valid,
    input  dec_to_exe_s dec,
    input  word_t       rd_data,
    output logic        wr_en,
    output addr_t       wr_addr,
    output word_t       wr_data,
    output logic        exe_valid,
    output exe_to_res_s exe
);

    localparam int IDX_W = $clog2(DEPTH);

    logic        ff_in_valid;
    dec_to_exe_s ff_in;
    word_t       amo_result;
    logic        is_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_in_valid <= 1'b0;
        end else if (flush) begin
            ff_in_valid <= 1'b0; // Keeps the flushed decode command from moving in
        end else if (!stall) begin
            ff_in_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_in <= dec;
        end
    end

    always_comb begin
        amo_result = ff_in.wdata;
        case (ff_in.amo_op)
            AMO_OP_SWAP: amo_result = ff_in.wdata;
            AMO_OP_ADD:  amo_result = rd_data + ff_in.wdata;
            AMO_OP_AND:  amo_result = rd_data & ff_in.wdata;
            AMO_OP_OR:   amo_result = rd_data | ff_in.wdata;
            AMO_OP_XOR:  amo_result = rd_data ^ ff_in.wdata;
            AMO_OP_MIN:  amo_result = ($signed(rd_data) < $signed(ff_in.wdata))
                                      ? rd_data : ff_in.wdata;
            AMO_OP_MAX:  amo_result = ($signed(rd_data) > $signed(ff_in.wdata))
                                      ? rd_data : ff_in.wdata;
            AMO_OP_MINU: amo_result = (rd_data < ff_in.wdata) ? rd_data : ff_in.wdata;
            AMO_OP_MAXU: amo_result = (rd_data > ff_in.wdata) ? rd_data : ff_in.wdata;
            default:     amo_result = ff_in.wdata;
        endcase
    end

    // Illegal commands carry MEM_OP_NONE, so they never write
    assign is_write = (ff_in.mem_op == MEM_OP_STORE) || (ff_in.mem_op == MEM_OP_AMO);

    assign exe_valid = ff_in_valid && !stall && !flush;
    assign wr_en     = exe_valid && is_write;
    assign wr_addr   = addr_t'(ff_in.addr[IDX_W-1:0]); // Wrapped to the memory size
    assign wr_data   = (ff_in.mem_op == MEM_OP_AMO) ? amo_result : ff_in.wdata;

    assign exe = '{
        tag:       ff_in.tag,
        mem_op:    ff_in.mem_op,
        illegal:   ff_in.illegal,
        mem_rdata: rd_data
    };

endmodule : amo_execute

// File: hw/amo_result.sv
// Response register of the atomic memory unit
// rsp_valid is a single-cycle pulse per command, there is no backpressure
// rdata is zero for stores and illegal commands

`timescale 1ns/1ps

module amo_result
    import amo_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        exe_valid,
    input  exe_to_res_s exe,
    output logic        rsp_valid,
    output amo_rsp_s    rsp
);

    word_t ret_data;

    always_comb begin
        // Loads and AMOs return the old word
        if ((exe.mem_op == MEM_OP_LOAD) || (exe.mem_op == MEM_OP_AMO)) begin
            ret_data = exe.mem_rdata;
        end else begin
            ret_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= exe_valid; // Falls again unless another command follows
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            rsp.tag     <= exe.tag;
            rsp.rdata   <= ret_data;
            rsp.illegal <= exe.illegal;
        end
    end

endmodule : amo_result

// File: hw/amo_dmem.sv
// Word memory with one synchronous read port and one write port
// Write-first: a read and a write to one index at the same edge return the new word
// DEPTH must be a power of two of at least 2, higher address bits are ignored
// Contents start at zero and are not cleared by reset

`timescale 1ns/1ps

module amo_dmem
    import amo_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic  clk,
    input  logic  rd_en,
    input  addr_t rd_addr,
    output word_t rd_data,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  word_t wr_data,
    input  logic  stall
);

    localparam int IDX_W = $clog2(DEPTH);

    word_t            mem [DEPTH] = '{default: '0};
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = rd_addr[IDX_W-1:0];
    assign wr_idx = wr_addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Held during a stall so execute still sees the word for its command
    always_ff @(posedge clk) begin
        if (rd_en && !stall) begin
            rd_data <= (wr_en && (wr_idx == rd_idx)) ? wr_data : mem[rd_idx];
        end
    end

endmodule : amo_dmem

// File: hw/amo_unit_top.sv
// Top level of the atomic memory unit
// Fixed two-cycle latency from command to response, one command per clock
// stall freezes every stage, flush drops the commands in decode and execute

`timescale 1ns/1ps

module amo_unit_top
    import amo_pkg::*;
#(
    parameter int DEPTH = DEFAULT_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  amo_req_s req,
    input  logic     stall,
    input  logic     flush,
    output logic     rsp_valid,
    output amo_rsp_s rsp
);

    logic        dec_valid;
    dec_to_exe_s dec;
    logic        rd_en;
    addr_t       rd_addr;
    word_t       rd_data;
    logic        wr_en;
    addr_t       wr_addr;
    word_t       wr_data;
    logic        exe_valid;
    exe_to_res_s exe;

    amo_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .stall     (stall),
        .flush     (flush),
        .dec_valid (dec_valid),
        .dec       (dec),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr)
    );

    amo_dmem #(.DEPTH(DEPTH)) u_dmem (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .stall   (stall)
    );

    amo_execute #(.DEPTH(DEPTH)) u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .dec_valid (dec_valid),
        .dec       (dec),
        .rd_data   (rd_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .exe_valid (exe_valid),
        .exe       (exe)
    );

    amo_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_valid (exe_valid),
        .exe       (exe),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule : amo_unit_top

// File: dv/amo_unit_asserts.sv
// Protocol checks for the atomic memory unit, bound onto its top level
// Port names match the top level's own signals

`timescale 1ns/1ps

module amo_unit_asserts
    import amo_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        stall,
    input logic        flush,
    input logic        wr_en,
    input logic        exe_valid,
    input logic        rsp_valid,
    input exe_to_res_s exe
);

    a_rsp_low_after_reset : assert property (
        @(posedge clk) !rst_n |=> !rsp_valid
    ) else $error("rsp_valid high in the cycle after reset");

    // A frozen or flushed pipeline must not touch memory
    a_no_write_on_hold : assert property (
        @(posedge clk) disable iff (!rst_n) (stall || flush) |-> !wr_en
    ) else $error("wr_en high during stall or flush");

    a_no_write_for_load : assert property (
        @(posedge clk) disable iff (!rst_n) wr_en |-> (exe.mem_op != MEM_OP_LOAD && !exe.illegal)
    ) else $error("wr_en high for a load or an illegal command");

    a_rsp_follows_exe : assert property (
        @(posedge clk) disable iff (!rst_n) rsp_valid == $past(exe_valid)
    ) else $error("rsp_valid does not follow exe_valid by one cycle");

endmodule : amo_unit_asserts

// File: dv/amo_unit_tb.sv
// Testbench for the atomic memory unit
// A fixed table covers every command, stall, flush and illegal codes, then random commands
// Expected data for the random phase comes from a shadow copy of the memory
// Responses are checked at the falling edge, in order, including the two-cycle latency

`timescale 1ns/1ps

module amo_unit_tb;
    import amo_pkg::*;

    localparam int DEPTH       = DEFAULT_DEPTH;
    localparam int STALL_LEN   = 3;
    localparam int TIMEOUT     = 40;
    localparam int NUM_RANDOM  = 200;
    localparam int NUM_VECTORS = 33;

    typedef struct packed {
        logic [4:0] cmd; // Raw code, so illegal values fit
        addr_t      addr;
        word_t      wdata;
        logic       stall;
        logic       flush;
        word_t      exp_rdata;
        logic       exp_illegal;
    } vector_s;

    typedef struct packed {
        tag_t        tag;
        word_t       rdata;
        logic        illegal;
        logic [31:0] due; // Falling-edge count at which the response must show
    } expect_s;

    localparam vector_s VECTORS [NUM_VECTORS] = '{
        '{CMD_STORE,   16'd1,  32'h1234_5678, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{CMD_LOAD,    16'd1,  32'h0000_0000, 1'b0, 1'b0, 32'h1234_5678, 1'b0},
        '{CMD_AMOSWAP, 16'd2,  32'hAAAA_0001, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{CMD_LOAD,    16'd2,  32'h0000_0000, 1'b0, 1'b0, 32'hAAAA_0001, 1'b0},
        '{CMD_AMOADD,  16'd3,  32'h0000_000A, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{CMD_AMOADD,  16'd3,  32'h0000_0005, 1'b0, 1'b0, 32'h0000_000A, 1'b0},
        '{CMD_AMOADD,  16'd3,  32'h0000_0004, 1'b0, 1'b0, 32'h0000_000F, 1'b0},
        '{CMD_LOAD,    16'd3,  32'h0000_0000, 1'b0, 1'b0, 32'h0000_0013, 1'b0},
        '{CMD_STORE,   16'd4,  32'hF0F0_00FF, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{CMD_AMOAND,  16'd4,  32'h0FF0_0F0F, 1'b0, 1'b0, 32'hF0F0_00FF, 1'b0},
        '{CMD_AMOOR,   16'd4,  32'h1200_0000, 1'b0, 1'b0, 32'h00F0_000F, 1'b0},
        '{CMD_AMOXOR,  16'd4,  32'hFFFF_FFFF, 1'b0, 1'b0, 32'h12F0_000F, 1'b0},
        '{CMD_LOAD,    16'd4,  32'h0000_0000, 1'b0, 1'b0, 32'hED0F_FFF0, 1'b0},
        '{CMD_STORE,   16'd5,  32'hFFFF_FFF0, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{CMD_AMOMIN,  16'd5,  32'h0000_0003, 1'b0, 1'b0, 32'hFFFF_FFF0, 1'b0},
        '{CMD_AMOMINU, 16'd5,  32'h0000_0003, 1'b0, 1'b0, 32'hFFFF_FFF0, 1'b0},
        '{CMD_AMOMAX,  16'd5,  32'hFFFF_FF00, 1'b0, 1'b0, 32'h0000_0003, 1'b0},
        '{CMD_AMOMAXU, 16'd5,  32'hFFFF_FF00, 1'b0, 1'b0, 32'h0000_0003, 1'b0},
        '{CMD_AMOMIN,  16'd5,  32'h8000_0000, 1'b0, 1'b0, 32'hFFFF_FF00, 1'b0},
        '{CMD_AMOMAX,  16'd5,  32'h7FFF_FFFF, 1'b0, 1'b0, 32'h8000_0000, 1'b0},
        '{CMD_LOAD,    16'd5,  32'h0000_0000, 1'b0, 1'b0, 32'h7FFF_FFFF, 1'b0},
        '{CMD_STORE,   16'd7,  32'hCAFE_0007, 1'b1, 1'b0, 32'h0000_0000, 1'b0},
        '{CMD_AMOADD,  16'd7,  32'h0000_0001, 1'b1, 1'b0, 32'hCAFE_0007, 1'b0},
        '{CMD_LOAD,    16'd7,  32'h0000_0000, 1'b0, 1'b0, 32'hCAFE_0008, 1'b0},
        '{CMD_STORE,   16'd8,  32'h5555_5555, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{CMD_STORE,   16'd8,  32'h0BAD_0BAD, 1'b0, 1'b1, 32'h0000_0000, 1'b0},
        '{CMD_AMOSWAP, 16'd8,  32'h1111_1111, 1'b0, 1'b1, 32'h0000_0000, 1'b0},
        '{CMD_LOAD,    16'd8,  32'h0000_0000, 1'b0, 1'b0, 32'h5555_5555, 1'b0},
        '{5'd5,        16'd8,  32'hFFFF_FFFF, 1'b0, 1'b0, 32'h0000_0000, 1'b1},
        '{5'd31,       16'd8,  32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000, 1'b1},
        '{CMD_LOAD,    16'd8,  32'h0000_0000, 1'b0, 1'b0, 32'h5555_5555, 1'b0},
        '{CMD_STORE,   16'd41, 32'h0000_0929, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{CMD_LOAD,    16'd9,  32'h0000_0000, 1'b0, 1'b0, 32'h0000_0929, 1'b0}
    };

    localparam logic [4:0] LEGAL_CODES [11] = '{
        CMD_AMOADD, CMD_AMOSWAP, CMD_LOAD, CMD_STORE, CMD_AMOXOR, CMD_AMOOR,
        CMD_AMOAND, CMD_AMOMIN, CMD_AMOMAX, CMD_AMOMINU, CMD_AMOMAXU
    };

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req_valid;
    amo_req_s    req;
    logic        stall;
    logic        flush;
    logic        rsp_valid;
    amo_rsp_s    rsp;

    expect_s     exp_q [$];
    string       name_q [$];
    word_t       shadow [DEPTH];
    int unsigned cyc = 0;
    int unsigned issued = 0;

    always #2 clk = ~clk;

    amo_unit_top #(.DEPTH(DEPTH)) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .stall     (stall),
        .flush     (flush),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    bind amo_unit_top amo_unit_asserts u_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .wr_en     (wr_en),
        .exe_valid (exe_valid),
        .rsp_valid (rsp_valid),
        .exe       (exe)
    );

    function automatic logic is_legal(input logic [4:0] cmd);
        case (cmd)
            CMD_AMOADD, CMD_AMOSWAP, CMD_LOAD, CMD_STORE, CMD_AMOXOR, CMD_AMOOR,
            CMD_AMOAND, CMD_AMOMIN, CMD_AMOMAX, CMD_AMOMINU, CMD_AMOMAXU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // New memory word after a command, loads and illegal codes keep the old one
    function automatic word_t amo_model(input logic [4:0] cmd, input word_t old, input word_t wdata);
        case (cmd)
            CMD_STORE, CMD_AMOSWAP: return wdata;
            CMD_AMOADD:  return old + wdata;
            CMD_AMOAND:  return old & wdata;
            CMD_AMOOR:   return old | wdata;
            CMD_AMOXOR:  return old ^ wdata;
            CMD_AMOMIN:  return ($signed(old) < $signed(wdata)) ? old : wdata;
            CMD_AMOMAX:  return ($signed(old) > $signed(wdata)) ? old : wdata;
            CMD_AMOMINU: return (old < wdata) ? old : wdata;
            CMD_AMOMAXU: return (old > wdata) ? old : wdata;
            default:     return old;
        endcase
    endfunction

    function automatic int mem_index(input addr_t addr);
        return int'(addr) % DEPTH; // Higher addresses wrap onto the array
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Presents one command at the next edge and queues its expected response
    task automatic send_cmd(input vector_s v, input string name);
        expect_s e;
        int      idx;
        @(posedge clk);
        req_valid <= 1'b1;
        req.cmd   <= cmd_code_e'(v.cmd);
        req.addr  <= v.addr;
        req.wdata <= v.wdata;
        req.tag   <= tag_t'(issued);
        if (!v.flush) begin
            e.tag     = tag_t'(issued);
            e.rdata   = v.exp_rdata;
            e.illegal = v.exp_illegal;
            e.due     = cyc + 4 + (v.stall ? STALL_LEN : 0);
            exp_q.push_back(e);
            name_q.push_back(name);
            idx         = mem_index(v.addr);
            shadow[idx] = amo_model(v.cmd, shadow[idx], v.wdata);
        end
        issued++;
    endtask

    // Freezes the last command in decode and the one before it in execute
    // A store offered during the stall must be dropped
    task automatic hold_stall(input addr_t addr);
        @(posedge clk);
        stall     <= 1'b1;
        req_valid <= 1'b1;
        req.cmd   <= CMD_STORE;
        req.addr  <= addr;
        req.wdata <= 32'hDEAD_BEEF;
        repeat (STALL_LEN) @(posedge clk);
        stall     <= 1'b0;
        req_valid <= 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        req_valid <= 1'b0;
        flush     <= 1'b1;
        @(posedge clk);
        flush     <= 1'b0;
    endtask

    task automatic wait_idle();
        int unsigned waited;
        waited = 0;
        @(posedge clk);
        req_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("Timed out waiting for rsp_valid");
            end
        end
    endtask

    always @(negedge clk) begin
        expect_s e;
        string   n;
        cyc = cyc + 1;
        if (rst_n && rsp_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("A response arrived with no command in flight");
            end else begin
                e = exp_q.pop_front();
                n = name_q.pop_front();
                check_equal($sformatf("%s tag", n), word_t'(e.tag), word_t'(rsp.tag));
                check_equal($sformatf("%s rdata", n), e.rdata, rsp.rdata);
                check_equal($sformatf("%s illegal", n), word_t'(e.illegal), word_t'(rsp.illegal));
                check_equal($sformatf("%s latency", n), e.due, word_t'(cyc));
            end
        end
    end

    initial begin
        vector_s     v;
        int unsigned r;
        int          idx;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        void'($urandom(5));
        for (int i = 0; i < DEPTH; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(negedge clk);
        check_equal("idle rsp_valid", 32'h0, word_t'(rsp_valid));

        // Neighbouring flagged vectors are in flight together, one in execute and one in decode
        for (int i = 0; i < NUM_VECTORS; i++) begin
            send_cmd(VECTORS[i], $sformatf("vector %0d", i));
            if (VECTORS[i].stall && (i == NUM_VECTORS - 1 || !VECTORS[i + 1].stall)) begin
                hold_stall(VECTORS[i].addr);
            end else if (VECTORS[i].flush
                         && (i == NUM_VECTORS - 1 || !VECTORS[i + 1].flush)) begin
                pulse_flush();
            end
        end
        wait_idle();

        // Few indices and several wrap aliases, so commands often hit one word back to back
        for (int i = 0; i < NUM_RANDOM; i++) begin
            v             = '0;
            r             = $urandom % 16;
            v.cmd         = (r < 11) ? LEGAL_CODES[r] : 5'($urandom);
            v.addr        = addr_t'(($urandom % 4) * DEPTH + ($urandom % 8));
            v.wdata       = $urandom;
            idx           = mem_index(v.addr);
            v.exp_illegal = !is_legal(v.cmd);
            v.exp_rdata   = (is_legal(v.cmd) && v.cmd != CMD_STORE) ? shadow[idx] : '0;
            send_cmd(v, $sformatf("random %0d", i));
        end
        wait_idle();

        $display("No errors");
        $finish;
    end

endmodule : amo_unit_tb

// File: project.f
hw/amo_pkg.sv
hw/amo_decode.sv
hw/amo_execute.sv
hw/amo_result.sv
hw/amo_dmem.sv
hw/amo_unit_top.sv
dv/amo_unit_asserts.sv
dv/amo_unit_tb.sv

// File: run.sh
#!/bin/sh
# Builds the atomic memory unit testbench with Verilator and runs it
# The exit status is nonzero when the build fails or the testbench stops with an error

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module amo_unit_tb -f project.f -o amo_unit_sim \
    && ./obj_dir/amo_unit_sim \
    || exit 1
